//--- design/commit_regfile.sv
`timescale 1ns/1ps
`include "fcpu_consts.svh"

module commit_regfile import fcpu_pkg::*; (
   input  logic                                     clk,
   input  logic                                     nrst,

   // operand lookup
   input  logic [`ROB_PORT_W-1:0][`REG_ADDR_W-1:0]  i_src_addr,
   output logic [`ROB_PORT_W-1:0][`DATA_W-1:0]      o_src_val,
   output logic [`ROB_PORT_W-1:0]                   o_src_pend,
   output logic [`ROB_PORT_W-1:0][`RSV_ID_W-1:0]    o_src_tag,

   // new writer
   input  logic                                     i_issue,
   input  logic [`REG_ADDR_W-1:0]                   i_issue_reg,
   input  logic [`RSV_ID_W-1:0]                     i_issue_tag,

   // commit stream
   input  logic                                     i_commit_valid,
   input  logic                                     i_commit_ready,
   input  station_t                                 i_commit,
   output logic [`REG_ADDR_W-1:0]                   o_commit_reg,
   output logic [`DATA_W-1:0]                       o_commit_data
);

   localparam int N_REGS = 2**`REG_ADDR_W;

   logic [`DATA_W-1:0]    regs     [N_REGS];
   logic [N_REGS-1:0]     pend;
   logic [`RSV_ID_W-1:0]  pend_tag [N_REGS];
   logic                  commit_fire;

   assign commit_fire = i_commit_valid && i_commit_ready;

   always_comb begin
      for (int p = 0; p < `ROB_PORT_W; p++) begin
         o_src_val[p]  = regs[i_src_addr[p]];
         o_src_pend[p] = pend[i_src_addr[p]];
         o_src_tag[p]  = pend_tag[i_src_addr[p]];
      end
   end

   always_ff @(posedge clk) begin
      if (nrst) begin
         pend <= '0;
         for (int r = 0; r < N_REGS; r++) begin
            regs[r] <= '0;
         end
      end else begin
         if (commit_fire) begin
            regs[i_commit.dst_reg] <= i_commit.content;
            // only the newest writer frees the register
            if (pend_tag[i_commit.dst_reg] == i_commit.station_id) begin
               pend[i_commit.dst_reg] <= 1'b0;
            end
         end
         if (i_issue) begin
            pend[i_issue_reg] <= 1'b1;  // overrides a same-cycle clear
         end
      end
   end

   always_ff @(posedge clk) begin
      if (i_issue) begin
         pend_tag[i_issue_reg] <= i_issue_tag;
      end
   end

   assign o_commit_reg  = i_commit.dst_reg;
   assign o_commit_data = i_commit.content;

endmodule

//--- design/decode_issue.sv
`timescale 1ns/1ps
`include "fcpu_consts.svh"

module decode_issue import fcpu_pkg::*; (
   input  logic                                      clk,
   input  logic                                      nrst,
   input  logic                                      i_valid,
   output logic                                      o_ready,
   input  instr_u                                    i_instr,
   output logic [`ROB_PORT_W-1:0][`REG_ADDR_W-1:0]   o_src_addr,
   input  logic [`ROB_PORT_W-1:0][`DATA_W-1:0]       i_src_val,
   input  logic [`ROB_PORT_W-1:0]                    i_src_pend,
   input  logic [`ROB_PORT_W-1:0][`RSV_ID_W-1:0]     i_src_tag,
   output logic [`ROB_PORT_W-1:0][`RSV_ID_W-1:0]     o_rob_id,
   input  logic [`ROB_PORT_W-1:0][`DATA_W-1:0]       i_rob_data,
   input  logic [`ROB_PORT_W-1:0]                    i_rob_filled,
   output logic                                      o_rsv_valid,
   input  logic                                      i_rsv_ready,
   input  logic [`RSV_ID_W-1:0]                      i_rsv_id,
   output logic [`REG_ADDR_W-1:0]                    o_dst_reg,
   output opcode_e                                   o_opcode,
   output logic                                      o_ex_valid,
   input  logic                                      i_ex_ready,
   output opcode_e                                   o_ex_op,
   output logic [`DATA_W-1:0]                        o_ex_a,
   output logic [`DATA_W-1:0]                        o_ex_b,
   output logic [`RSV_ID_W-1:0]                      o_ex_tag
);

   opcode_e                               op;
   logic                                  is_imm;
   logic [`ROB_PORT_W-1:0]                need;
   logic [`ROB_PORT_W-1:0]                avail;
   logic [`ROB_PORT_W-1:0][`DATA_W-1:0]   opnd;
   logic [`DATA_W-1:0]                    imm_val;
   logic                                  rst_done;

   always_comb begin
      case (i_instr.r.opcode)
         OP_ADD, OP_SUB, OP_AND, OP_XOR,
         OP_ADDI, OP_LUI, OP_MUL: op = opcode_e'(i_instr.r.opcode);
         default:                 op = OP_ADD;  // illegal codes
      endcase
   end

   assign is_imm  = (op == OP_ADDI) || (op == OP_LUI);
   assign need[0] = (op != OP_LUI);
   assign need[1] = !is_imm;

   // lui fills the top bits, addi sign-extends
   assign imm_val = (op == OP_LUI) ?
                    {i_instr.i.imm, {(`DATA_W-`IMM_W){1'b0}}} :
                    {{(`DATA_W-`IMM_W){i_instr.i.imm[`IMM_W-1]}}, i_instr.i.imm};

   assign o_src_addr[0] = i_instr.r.src1;
   assign o_src_addr[1] = i_instr.r.src2;

   always_comb begin
      for (int p = 0; p < `ROB_PORT_W; p++) begin
         o_rob_id[p] = i_src_tag[p];
         opnd[p]     = i_src_pend[p] ? i_rob_data[p] : i_src_val[p];
         avail[p]    = !need[p] || !i_src_pend[p] || i_rob_filled[p];
      end
   end

   always_ff @(posedge clk) begin
      if (nrst) begin
         rst_done <= 1'b0;
      end else begin
         rst_done <= 1'b1;
      end
   end

   assign o_ready     = rst_done && i_rsv_ready && i_ex_ready && (&avail);
   assign o_rsv_valid = i_valid && o_ready;
   assign o_ex_valid  = i_valid && o_ready;

   assign o_dst_reg = i_instr.r.dst;
   assign o_opcode  = op;
   assign o_ex_op   = op;
   assign o_ex_a    = opnd[0];
   assign o_ex_b    = is_imm ? imm_val : opnd[1];
   assign o_ex_tag  = i_rsv_id;

endmodule

//--- design/exec_unit.sv
`timescale 1ns/1ps
`include "fcpu_consts.svh"

module exec_unit import fcpu_pkg::*; (
   input  logic                  clk,
   input  logic                  nrst,
   input  logic                  i_valid,
   output logic                  i_ready,
   input  opcode_e               i_op,
   input  logic [`DATA_W-1:0]    i_a,
   input  logic [`DATA_W-1:0]    i_b,
   input  logic [`RSV_ID_W-1:0]  i_tag,
   output logic                  o_cdb_valid,
   output logic [`CDB_W-1:0]     o_cdb
);

   localparam int LAST = `MUL_LAT - 1;

   logic                  alu_in;
   logic                  mul_in;
   logic                  mul_out;
   logic [`DATA_W-1:0]    alu_res_n;
   logic [`DATA_W-1:0]    mul_lo;

   // alu output register
   logic                  alu_valid;
   logic [`RSV_ID_W-1:0]  alu_tag;
   logic [`DATA_W-1:0]    alu_res;

   // multiplier pipe
   logic [`MUL_LAT-1:0]   mul_v;
   logic [`RSV_ID_W-1:0]  mul_tag [`MUL_LAT];
   logic [`DATA_W-1:0]    mul_p   [`MUL_LAT];

   assign alu_in  = i_valid && i_ready && (i_op != OP_MUL);
   assign mul_in  = i_valid && i_ready && (i_op == OP_MUL);
   assign mul_out = mul_v[LAST];

   // low half of the product only
   assign mul_lo = i_a * i_b;

   // no new op while a held alu result still waits for the bus
   assign i_ready = !(alu_valid && mul_out);

   always_comb begin
      case (i_op)
         OP_SUB:  alu_res_n = i_a - i_b;
         OP_AND:  alu_res_n = i_a & i_b;
         OP_XOR:  alu_res_n = i_a ^ i_b;
         OP_LUI:  alu_res_n = i_b;  // immediate already shifted
         default: alu_res_n = i_a + i_b;  // add, addi
      endcase
   end

   always_ff @(posedge clk) begin
      if (nrst) begin
         alu_valid <= 1'b0;
      end else if (alu_in) begin
         alu_valid <= 1'b1;
      end else if (!mul_out) begin
         alu_valid <= 1'b0;  // sent this cycle
      end
   end

   always_ff @(posedge clk) begin
      if (alu_in) begin
         alu_tag <= i_tag;
         alu_res <= alu_res_n;
      end
   end

   always_ff @(posedge clk) begin
      if (nrst) begin
         mul_v <= '0;
      end else begin
         mul_v <= {mul_v[LAST-1:0], mul_in};
      end
   end

   always_ff @(posedge clk) begin
      mul_tag[0] <= i_tag;
      mul_p[0]   <= mul_lo;
      for (int s = 1; s < `MUL_LAT; s++) begin
         mul_tag[s] <= mul_tag[s-1];
         mul_p[s]   <= mul_p[s-1];
      end
   end

   // multiplier wins the bus
   assign o_cdb_valid = mul_out || alu_valid;
   assign o_cdb       = mul_out ? {mul_tag[LAST], mul_p[LAST]} : {alu_tag, alu_res};

endmodule

//--- design/fcpu_core.sv
`timescale 1ns/1ps
`include "fcpu_consts.svh"

module fcpu_core import fcpu_pkg::*; (
   input  logic                    clk,
   input  logic                    nrst,
   input  logic                    i_valid,
   output logic                    o_ready,
   input  instr_u                  i_instr,
   output logic                    o_commit_valid,
   output logic [`REG_ADDR_W-1:0]  o_commit_reg,
   output logic [`DATA_W-1:0]      o_commit_data,
   input  logic                    i_commit_ready
);

   logic [`ROB_PORT_W-1:0][`REG_ADDR_W-1:0]  src_addr;
   logic [`ROB_PORT_W-1:0][`DATA_W-1:0]      src_val;
   logic [`ROB_PORT_W-1:0]                   src_pend;
   logic [`ROB_PORT_W-1:0][`RSV_ID_W-1:0]    src_tag;
   logic [`ROB_PORT_W-1:0][`RSV_ID_W-1:0]    rob_id;
   logic [`ROB_PORT_W-1:0][`DATA_W-1:0]      rob_data;
   logic [`ROB_PORT_W-1:0]                   rob_filled;

   logic                    rsv_valid;
   logic                    rsv_ready;
   logic [`RSV_ID_W-1:0]    rsv_id;
   logic [`REG_ADDR_W-1:0]  dst_reg;
   opcode_e                 dec_op;

   logic                    ex_valid;
   logic                    ex_ready;
   opcode_e                 ex_op;
   logic [`DATA_W-1:0]      ex_a;
   logic [`DATA_W-1:0]      ex_b;
   logic [`RSV_ID_W-1:0]    ex_tag;

   logic                    cdb_valid;
   logic [`CDB_W-1:0]       cdb;
   station_t                head;

   decode_issue u_decode (
      .clk, .nrst, .i_valid, .o_ready, .i_instr,
      .o_src_addr(src_addr), .i_src_val(src_val), .i_src_pend(src_pend), .i_src_tag(src_tag),
      .o_rob_id(rob_id), .i_rob_data(rob_data), .i_rob_filled(rob_filled),
      .o_rsv_valid(rsv_valid), .i_rsv_ready(rsv_ready), .i_rsv_id(rsv_id),
      .o_dst_reg(dst_reg), .o_opcode(dec_op),
      .o_ex_valid(ex_valid), .i_ex_ready(ex_ready), .o_ex_op(ex_op),
      .o_ex_a(ex_a), .o_ex_b(ex_b), .o_ex_tag(ex_tag)
   );

   reorder_buffer u_rob (
      .clk, .nrst,
      .i_valid(rsv_valid), .i_ready(rsv_ready), .i_rsv_id(rsv_id),
      .i_dst_reg(dst_reg), .i_opcode(dec_op),
      .rob_id(rob_id), .rob_data(rob_data), .rob_data_filled(rob_filled),
      .o_valid(o_commit_valid), .o_commit_data(head), .o_ready(i_commit_ready),
      .cdb_valid(cdb_valid), .cdb(cdb)
   );

   exec_unit u_exec (
      .clk, .nrst,
      .i_valid(ex_valid), .i_ready(ex_ready), .i_op(ex_op),
      .i_a(ex_a), .i_b(ex_b), .i_tag(ex_tag),
      .o_cdb_valid(cdb_valid), .o_cdb(cdb)
   );

   commit_regfile u_regfile (
      .clk, .nrst,
      .i_src_addr(src_addr), .o_src_val(src_val), .o_src_pend(src_pend), .o_src_tag(src_tag),
      .i_issue(rsv_valid), .i_issue_reg(dst_reg), .i_issue_tag(rsv_id),
      .i_commit_valid(o_commit_valid), .i_commit_ready(i_commit_ready), .i_commit(head),
      .o_commit_reg(o_commit_reg), .o_commit_data(o_commit_data)
   );

endmodule

//--- design/fcpu_pkg.sv
`include "fcpu_consts.svh"

package fcpu_pkg;

   typedef enum logic [`OPCODE_W-1:0] {
      OP_ADD  = 4'h0,
      OP_SUB  = 4'h1,
      OP_AND  = 4'h2,
      OP_XOR  = 4'h3,
      OP_ADDI = 4'h4,
      OP_LUI  = 4'h5,
      OP_MUL  = 4'h6
   } opcode_e;

   // register form
   typedef struct packed {
      logic [`OPCODE_W-1:0]   opcode;
      logic [`REG_ADDR_W-1:0] dst;
      logic [`REG_ADDR_W-1:0] src1;
      logic [`REG_ADDR_W-1:0] src2;
      logic [2:0]             unused;
   } r_fmt_t;

   // immediate form
   typedef struct packed {
      logic [`OPCODE_W-1:0]   opcode;
      logic [`REG_ADDR_W-1:0] dst;
      logic [`REG_ADDR_W-1:0] src1;
      logic [`IMM_W-1:0]      imm;
   } i_fmt_t;

   typedef union packed {
      r_fmt_t r;
      i_fmt_t i;
   } instr_u;

   typedef struct packed {
      logic                   valid;
      logic                   ready;  // result written
      logic [`RSV_ID_W-1:0]   station_id;
      logic [`REG_ADDR_W-1:0] dst_reg;
      opcode_e                opcode;
      logic [`DATA_W-1:0]     content;
   } station_t;

endpackage

//--- design/reorder_buffer.sv
`timescale 1ns/1ps
`include "fcpu_consts.svh"

module reorder_buffer import fcpu_pkg::*; (
   input  logic                                   clk,
   input  logic                                   nrst,

   // reservation
   input  logic                                   i_valid,
   output logic                                   i_ready,
   output logic [`RSV_ID_W-1:0]                   i_rsv_id,
   input  logic [`REG_ADDR_W-1:0]                 i_dst_reg,
   input  opcode_e                                i_opcode,

   // operand read ports
   input  logic [`ROB_PORT_W-1:0][`RSV_ID_W-1:0]  rob_id,
   output logic [`ROB_PORT_W-1:0][`DATA_W-1:0]    rob_data,
   output logic [`ROB_PORT_W-1:0]                 rob_data_filled,

   // commit
   output logic                                   o_valid,
   output station_t                               o_commit_data,
   input  logic                                   o_ready,

   // result bus
   input  logic                                   cdb_valid,
   input  logic [`CDB_W-1:0]                      cdb
);

   localparam int N_ST = 2**`N_ROB_W;

   station_t                 station   [N_ST];
   station_t                 station_n [N_ST];
   station_t                 head_station;

   logic [`N_ROB_W-1:0]      rob_head;
   logic [`N_ROB_W-1:0]      rob_tail;
   logic                     do_reserve;
   logic                     do_release;

   logic [`RSV_ID_W-1:0]     cdb_tag;
   logic [`DATA_W-1:0]       cdb_data;

   assign cdb_tag  = cdb[`DATA_W +: `RSV_ID_W];
   assign cdb_data = cdb[`DATA_W-1:0];

   assign head_station  = station[rob_head];
   assign o_valid       = head_station.valid && head_station.ready;
   assign o_commit_data = head_station;

   // full when head is live and tail caught up
   assign i_ready  = !(head_station.valid && (rob_head == rob_tail));
   assign i_rsv_id = rob_tail;

   assign do_reserve = i_valid && i_ready;
   assign do_release = o_valid && o_ready;

   always_comb begin
      for (int p = 0; p < `ROB_PORT_W; p++) begin
         rob_data[p]        = station[rob_id[p]].content;
         rob_data_filled[p] = station[rob_id[p]].ready;
      end
   end

   always_comb begin
      for (int s = 0; s < N_ST; s++) begin
         station_n[s] = station[s];

         if (cdb_valid && (cdb_tag == `RSV_ID_W'(s))) begin
            station_n[s].ready   = 1'b1;
            station_n[s].content = cdb_data;
         end

         if (do_release && (rob_head == `N_ROB_W'(s))) begin
            station_n[s] = '0;
         end else if (do_reserve && (rob_tail == `N_ROB_W'(s))) begin
            station_n[s].valid      = 1'b1;
            station_n[s].ready      = 1'b0;
            station_n[s].station_id = `RSV_ID_W'(s);
            station_n[s].dst_reg    = i_dst_reg;
            station_n[s].opcode     = i_opcode;
            station_n[s].content    = '0;
         end
      end
   end

   always_ff @(posedge clk) begin
      for (int s = 0; s < N_ST; s++) begin
         if (nrst) begin
            station[s] <= '0;
         end else begin
            station[s] <= station_n[s];
         end
      end
   end

   // pointers wrap over the power of two stations
   always_ff @(posedge clk) begin
      if (nrst) begin
         rob_head <= '0;
         rob_tail <= '0;
      end else begin
         if (do_release) begin
            rob_head <= rob_head + 1'b1;
         end
         if (do_reserve) begin
            rob_tail <= rob_tail + 1'b1;
         end
      end
   end

endmodule

//--- files.f
+incdir+include
design/fcpu_pkg.sv
design/decode_issue.sv
design/reorder_buffer.sv
design/exec_unit.sv
design/commit_regfile.sv
design/fcpu_core.sv
testbench/fcpu_properties.sv
testbench/fcpu_tb.sv

//--- include/fcpu_consts.svh
`ifndef FCPU_CONSTS_SVH
`define FCPU_CONSTS_SVH

// datapath
`define DATA_W      16
`define INSTR_W     16

// instruction fields
`define OPCODE_W    4
`define IMM_W       6
`define REG_ADDR_W  3   // 8 registers and r0 is ordinary

// reorder buffer
`define N_ROB_W     3   // 8 stations
`define RSV_ID_W    `N_ROB_W
`define ROB_PORT_W  2

// result bus with the tag above the data
`define CDB_W       (`RSV_ID_W + `DATA_W)

// multiplier depth
`define MUL_LAT     3

`endif

//--- run.sh
#!/bin/sh
# build and run the fcpu testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module fcpu_tb -f files.f \
   && ./obj_dir/Vfcpu_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^TESTS PASSED$" sim.log && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

//--- testbench/fcpu_properties.sv
`timescale 1ns/1ps
`include "fcpu_consts.svh"

module fcpu_properties import fcpu_pkg::*; (
   input logic                  clk,
   input logic                  nrst,
   input logic                  i_valid,
   input logic                  o_valid,
   input logic                  o_ready,
   input station_t              head_station,
   input logic [`N_ROB_W-1:0]   rob_head,
   input logic [`N_ROB_W-1:0]   rob_tail,
   input logic                  cdb_valid,
   input logic [`RSV_ID_W-1:0]  cdb_tag,
   input station_t              station [2**`N_ROB_W]
);

   logic rob_full;

   assign rob_full = head_station.valid && (rob_head == rob_tail);

   no_rsv_when_full: assert property (@(posedge clk) disable iff (nrst)
      rob_full |-> !i_valid)
      else $error("reservation while the reorder buffer is full");

   // a stalled head keeps its station until it retires
   head_holds_under_stall: assert property (@(posedge clk) disable iff (nrst)
      (o_valid && !o_ready) |=> (o_valid && $stable(head_station)))
      else $error("head station changed while commit was stalled");

   // results only for reserved stations still waiting
   cdb_names_open_station: assert property (@(posedge clk) disable iff (nrst)
      cdb_valid |-> (station[cdb_tag].valid && !station[cdb_tag].ready))
      else $error("result bus tag names an empty or filled station");

endmodule

bind reorder_buffer fcpu_properties u_props (
   .clk, .nrst, .i_valid, .o_valid, .o_ready, .head_station, .rob_head, .rob_tail,
   .cdb_valid, .cdb_tag, .station
);

//--- testbench/fcpu_tb.sv
`timescale 1ns/1ps
`include "fcpu_consts.svh"

module fcpu_tb import fcpu_pkg::*; ();

   localparam int N_INSTR      = 400;
   localparam int RESET_CYC    = 8;
   localparam int WATCHDOG_CYC = RESET_CYC + N_INSTR * 40;
   localparam int STALL_AT     = 200;  // accepted count that starts the long stall
   localparam int STALL_CYC    = 60;
   localparam logic [31:0] SEED = 32'd68091;

   logic                    clk;
   logic                    nrst;
   logic                    i_valid;
   logic                    o_ready;
   instr_u                  i_instr;
   logic                    o_commit_valid;
   logic [`REG_ADDR_W-1:0]  o_commit_reg;
   logic [`DATA_W-1:0]      o_commit_data;
   logic                    i_commit_ready;

   logic [31:0]             lfsr_state;
   logic [`INSTR_W-1:0]     cur_word;
   logic                    pending;
   int                      stall_left;
   int                      n_accept;
   int                      n_commit;
   logic [`DATA_W-1:0]      model_regs [2**`REG_ADDR_W];
   station_t                exp_q [$];

   fcpu_core dut (
      .clk(clk), .nrst(nrst),
      .i_valid(i_valid), .o_ready(o_ready), .i_instr(i_instr),
      .o_commit_valid(o_commit_valid), .o_commit_reg(o_commit_reg),
      .o_commit_data(o_commit_data), .i_commit_ready(i_commit_ready)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [31:0] draw_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int k = 0; k < n; k++) begin
         lfsr_state = lfsr_next(lfsr_state);
         v = {v[30:0], lfsr_state[0]};
      end
      return v;
   endfunction

   task automatic report_error(input string why);
      $display("%s", why);
      $display("TESTS FAILED");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic check_reg(input string name, input logic [`REG_ADDR_W-1:0] got,
                            input logic [`REG_ADDR_W-1:0] exp);
      if (got !== exp) begin
         report_error($sformatf("MISMATCH %s got %h expected %h at commit %0d",
                                name, got, exp, n_commit));
      end
   endtask

   task automatic check_data(input string name, input logic [`DATA_W-1:0] got,
                             input logic [`DATA_W-1:0] exp);
      if (got !== exp) begin
         report_error($sformatf("MISMATCH %s got %h expected %h at commit %0d",
                                name, got, exp, n_commit));
      end
   endtask

   // in-order reference model
   // opcode 15:12 dst 11:9 src1 8:6 src2 5:3 imm 5:0
   task automatic model_issue(input logic [`INSTR_W-1:0] w);
      logic [3:0]          opc;
      logic [2:0]          dst;
      logic [5:0]          imm;
      logic [`DATA_W-1:0]  a;
      logic [`DATA_W-1:0]  b;
      logic [`DATA_W-1:0]  res;
      station_t            exp;
      opc = w[15:12];
      dst = w[11:9];
      imm = w[5:0];
      a   = model_regs[w[8:6]];
      b   = model_regs[w[5:3]];
      case (opc)
         OP_SUB:  res = a - b;
         OP_AND:  res = a & b;
         OP_XOR:  res = a ^ b;
         OP_ADDI: res = a + {{10{imm[5]}}, imm};
         OP_LUI:  res = {imm, 10'b0};
         OP_MUL:  res = a * b;  // low half
         default: res = a + b;  // add and illegal codes
      endcase
      exp         = '0;
      exp.valid   = 1'b1;
      exp.dst_reg = dst;
      exp.content = res;
      exp_q.push_back(exp);
      model_regs[dst] = res;
   endtask

   task automatic drive_cycle();
      logic [2:0] sel;
      if (!pending && (n_accept < N_INSTR)) begin
         if (draw_bits(2) != 0) begin
            sel = 3'(draw_bits(3));
            cur_word[15:12] = (sel == 3'd7) ? 4'hf : {1'b0, sel};  // 7 -> illegal code
            cur_word[11:0]  = 12'(draw_bits(12));
            pending = 1'b1;
         end
      end
      i_valid = pending;
      i_instr = cur_word;
      if (stall_left > 0) begin
         i_commit_ready = 1'b0;
         stall_left--;
      end else begin
         i_commit_ready = (draw_bits(8) < 154);
      end
   endtask

   // handshakes seen here complete at the next rising edge
   task automatic observe();
      station_t exp;
      if (o_commit_valid && (n_accept == 0)) begin
         report_error("commit output active before any instruction was accepted");
      end
      if (o_commit_valid && i_commit_ready) begin
         if (exp_q.size() == 0) begin
            report_error("commit handshake with no accepted instruction left to retire");
         end
         exp = exp_q.pop_front();
         check_reg("o_commit_reg", o_commit_reg, exp.dst_reg);
         check_data("o_commit_data", o_commit_data, exp.content);
         n_commit++;
      end
      if (i_valid && o_ready) begin
         model_issue(cur_word);
         pending = 1'b0;
         n_accept++;
         if (n_accept == STALL_AT) begin
            stall_left = STALL_CYC;
         end
      end
   endtask

   initial begin
      int wait_cyc;
      nrst           = 1'b1;
      i_valid        = 1'b0;
      i_instr        = '0;
      i_commit_ready = 1'b0;
      lfsr_state     = SEED;
      cur_word       = '0;
      pending        = 1'b0;
      stall_left     = 0;
      n_accept       = 0;
      n_commit       = 0;
      for (int r = 0; r < 2**`REG_ADDR_W; r++) begin
         model_regs[r] = '0;
      end
      repeat (RESET_CYC) @(posedge clk);
      #1 nrst = 1'b0;

      wait_cyc = 0;
      @(negedge clk);
      while (!o_ready) begin
         if (o_commit_valid) begin
            report_error("commit output active right after reset");
         end
         if (wait_cyc == 16) begin
            report_error("o_ready did not rise after reset");
         end
         wait_cyc++;
         @(negedge clk);
      end

      while (n_commit < N_INSTR) begin
         @(posedge clk);
         #1;
         drive_cycle();
         @(negedge clk);
         observe();
      end

      // idle tail catches duplicated commits
      repeat (20) begin
         @(posedge clk);
         #1;
         i_valid        = 1'b0;
         i_commit_ready = 1'b1;
         @(negedge clk);
         observe();
      end

      $display("TESTS PASSED");
      $finish;
   end

   initial begin
      repeat (WATCHDOG_CYC) @(posedge clk);
      report_error($sformatf("watchdog expired, %0d accepted and %0d committed",
                             n_accept, n_commit));
   end

endmodule
